/* verilog.f */
+incdir+.
core_pkg.sv
pipe_pkg.sv
mem_bus_if.sv
reg_file.sv
stage_reg.sv
fetch_stage.sv
execute_stage.sv
mem_wb_stage.sv
bus_arbiter.sv
riscv_core.sv
tb_riscv_core.sv

/* Bender.yml */
package:
  name: riscv_core

sources:
  - core_pkg.sv
  - pipe_pkg.sv
  - mem_bus_if.sv
  - reg_file.sv
  - stage_reg.sv
  - fetch_stage.sv
  - execute_stage.sv
  - mem_wb_stage.sv
  - bus_arbiter.sv
  - riscv_core.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_riscv_core.sv

/* tb_isa_model.svh */
// ISA model for the core testbench with instruction encoders and a reference interpreter
`ifndef TB_ISA_MODEL_SVH
`define TB_ISA_MODEL_SVH

typedef enum int {
  k_addi, k_add, k_sub, k_and, k_or, k_xor, k_lui, k_ld, k_sd, k_sb, k_beq, k_bne, k_jal
} kind_e;

kind_e       p_kind [prog_len];
logic [4:0]  p_rd   [prog_len];
logic [4:0]  p_rs1  [prog_len];
logic [4:0]  p_rs2  [prog_len];
logic [20:0] p_imm  [prog_len];
logic [31:0] p_word [prog_len];

// expected event streams in program order
logic [63:0] exp_addr [$];
logic [63:0] exp_data [$];
logic        exp_size [$];
logic [7:0]  exp_uart [$];

// RV64 base encodings where imm holds the byte offset or the upper 20 bits for LUI
function automatic logic [31:0] encode(kind_e k, logic [4:0] rd, logic [4:0] rs1,
                                       logic [4:0] rs2, logic [20:0] imm);
  case (k)
    k_addi:  return {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
    k_add:   return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
    k_sub:   return {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
    k_and:   return {7'b0000000, rs2, rs1, 3'b111, rd, 7'b0110011};
    k_or:    return {7'b0000000, rs2, rs1, 3'b110, rd, 7'b0110011};
    k_xor:   return {7'b0000000, rs2, rs1, 3'b100, rd, 7'b0110011};
    k_lui:   return {imm[19:0], rd, 7'b0110111};
    k_ld:    return {imm[11:0], rs1, 3'b011, rd, 7'b0000011};
    k_sd:    return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], 7'b0100011};
    k_sb:    return {imm[11:5], rs2, rs1, 3'b000, imm[4:0], 7'b0100011};
    k_beq:   return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
    k_bne:   return {imm[12], imm[10:5], rs2, rs1, 3'b001, imm[4:1], imm[11], 7'b1100011};
    default: return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endcase
endfunction

task automatic set_instr(int i, kind_e k, logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2,
                         logic [20:0] imm);
  p_kind[i] = k;
  p_rd[i]   = rd;
  p_rs1[i]  = rs1;
  p_rs2[i]  = rs2;
  p_imm[i]  = imm;
  p_word[i] = encode(k, rd, rs1, rs2, imm);
endtask

// contents of unwritten memory folded over every address bit
function automatic logic [7:0] fill_byte(logic [63:0] a);
  logic [7:0] f;
  f = 8'h5a;
  for (int i = 0; i < 8; i++) begin
    f = f ^ a[8*i +: 8];
  end
  return f;
endfunction

// runs from index 0 up to the final self jump
task automatic run_model();
  logic [63:0] x [32];
  logic [63:0] model_mem [logic [63:0]];
  logic [63:0] a;
  logic [63:0] b;
  logic [63:0] v;
  int          idx;
  int          next;
  kind_e       k;
  for (int i = 0; i < 32; i++) begin
    x[i] = '0;
  end
  idx = 0;
  while (idx != prog_len - 1) begin
    k    = p_kind[idx];
    a    = x[p_rs1[idx]] + {{52{p_imm[idx][11]}}, p_imm[idx][11:0]};
    b    = x[p_rs2[idx]];
    v    = '0;
    next = idx + 1;
    case (k)
      k_addi: v = a;
      k_add:  v = x[p_rs1[idx]] + b;
      k_sub:  v = x[p_rs1[idx]] - b;
      k_and:  v = x[p_rs1[idx]] & b;
      k_or:   v = x[p_rs1[idx]] | b;
      k_xor:  v = x[p_rs1[idx]] ^ b;
      k_lui:  v = {{32{p_imm[idx][19]}}, p_imm[idx][19:0], 12'h000};
      k_ld: begin
        for (int i = 0; i < 8; i++) begin
          v[8*i +: 8] = fill_byte(a + i);
        end
        if (model_mem.exists(a)) begin
          v = model_mem[a];
        end
      end
      k_sd: begin
        model_mem[a] = b;
        exp_addr.push_back(a);
        exp_data.push_back(b);
        exp_size.push_back(1'b1);
      end
      k_sb:  exp_uart.push_back(b[7:0]);
      k_beq: if (x[p_rs1[idx]] == b) next = idx + int'(p_imm[idx]) / 4;
      k_bne: if (x[p_rs1[idx]] != b) next = idx + int'(p_imm[idx]) / 4;
      default: begin
        v    = 64'(4 * idx + 4);
        next = idx + int'(p_imm[idx]) / 4;
      end
    endcase
    if (k != k_sd && k != k_sb && k != k_beq && k != k_bne && p_rd[idx] != 5'd0) begin
      x[p_rd[idx]] = v;
    end
    idx = next;
  end
endtask

`endif

/* tb_riscv_core.sv */
// testbench for the RV64 core with a random program, a bus memory responder and model checks
`default_nettype none

module tb_riscv_core;
  timeunit 1ns;
  timeprecision 1ps;
  import core_pkg::*;
  import pipe_pkg::*;

  localparam int    prog_len  = 64;
  localparam word_t data_base = 64'h0000_0000_0000_1000;
  localparam word_t uart_addr = 64'h0000_0000_1000_0000;

  logic       clock;
  logic       reset;
  logic       bus_valid;
  logic       bus_ready;
  logic       bus_write;
  word_t      bus_addr;
  word_t      bus_wdata;
  bus_size_e  bus_size;
  word_t      bus_rdata;
  logic       uart_valid;
  logic [7:0] uart_char;

  logic [7:0] bus_mem [word_t];
  logic       first_req = 1'b1;

  `include "tb_isa_model.svh"

  riscv_core #(.reset_pc('0), .uart_addr(uart_addr)) UUT (
    .clock(clock), .reset(reset),
    .bus_valid(bus_valid), .bus_ready(bus_ready), .bus_write(bus_write),
    .bus_addr(bus_addr), .bus_wdata(bus_wdata), .bus_size(bus_size),
    .bus_rdata(bus_rdata), .uart_valid(uart_valid), .uart_char(uart_char)
  );

  task automatic stop_with_failure(string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(string name, logic [63:0] actual, logic [63:0] expected);
    if (actual !== expected) begin
      stop_with_failure($sformatf("CHECK FAILED at %0t: %s is %h, expected %h",
                                  $time, name, actual, expected));
    end
  endtask

  function automatic word_t read_bus_mem(word_t a);
    word_t d;
    for (int i = 0; i < 8; i++) begin
      d[8*i +: 8] = bus_mem.exists(a + i) ? bus_mem[a + i] : fill_byte(a + i);
    end
    return d;
  endfunction

  // compare one bus write with the oldest store of the model
  task automatic record_store(word_t a, word_t d, bus_size_e sz);
    word_t mask;
    if (exp_addr.size() == 0) begin
      stop_with_failure($sformatf("unexpected bus write to %h after all model stores", a));
    end else begin
      mask = (sz == size_dword) ? '1 : 64'hff;
      check_value("bus_addr", a, exp_addr[0]);
      check_value("bus_size", sz, exp_size[0]);
      check_value("bus_wdata", d & mask, exp_data[0] & mask);
      exp_addr.delete(0);
      exp_data.delete(0);
      exp_size.delete(0);
      for (int i = 0; i < ((sz == size_dword) ? 8 : 1); i++) begin
        bus_mem[a + i] = d[8*i +: 8];
      end
    end
  endtask

  function automatic logic [4:0] rand_dst();
    return 5'($urandom_range(7, 2));
  endfunction

  function automatic logic [4:0] rand_src();
    return 5'($urandom_range(8, 0));
  endfunction

  // x1 holds the data window and x8 the UART address
  task automatic gen_program();
    int r;
    int skip;
    set_instr(0, k_lui, 5'd1, 5'd0, 5'd0, 21'(data_base >> 12));
    set_instr(1, k_lui, 5'd8, 5'd0, 5'd0, 21'(uart_addr >> 12));
    for (int i = 2; i < prog_len - 1; i++) begin
      r    = $urandom_range(9, 0);
      skip = $urandom_range(3, 1);
      if (i + skip > prog_len - 2) begin
        skip = prog_len - 2 - i;
      end
      case (r)
        0, 1: set_instr(i, k_addi, rand_dst(), rand_src(), 5'd0, 21'($urandom_range(4095, 0)));
        2, 3: set_instr(i, kind_e'(k_add + $urandom_range(4, 0)), rand_dst(), rand_src(),
                        rand_src(), 21'd0);
        4: set_instr(i, k_lui, rand_dst(), 5'd0, 5'd0, 21'($urandom));
        5: set_instr(i, k_ld, rand_dst(), 5'd1, 5'd0, 21'(8 * $urandom_range(7, 0)));
        6: set_instr(i, k_sd, 5'd0, 5'd1, rand_src(), 21'(8 * $urandom_range(7, 0)));
        7: set_instr(i, k_sb, 5'd0, 5'd8, rand_src(), 21'd0);
        8: set_instr(i, ($urandom_range(1, 0) != 0) ? k_beq : k_bne, 5'd0, rand_src(),
                     rand_src(), 21'(4 * (skip + 1)));
        default: set_instr(i, k_jal, rand_dst(), 5'd0, 5'd0, 21'(4 * (skip + 1)));
      endcase
    end
    set_instr(prog_len - 1, k_jal, 5'd0, 5'd0, 5'd0, 21'd0);
  endtask

  initial begin : clock_gen
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  // ready follows a random delay of 0..3 cycles while the request holds steady
  initial begin : responder
    word_t     a;
    word_t     wd;
    logic      w;
    bus_size_e sz;
    int        delay;
    bus_ready = 1'b0;
    bus_rdata = '0;
    forever begin
      @(negedge clock);
      bus_ready = 1'b0;
      if (!reset && bus_valid) begin
        a  = bus_addr;
        w  = bus_write;
        wd = bus_wdata;
        sz = bus_size;
        if (first_req) begin
          check_value("bus_write", w, 1'b0);
          check_value("bus_addr", a, 64'd0);
          first_req = 1'b0;
        end
        if (a == uart_addr) begin
          stop_with_failure("the UART address appeared on the memory bus");
        end
        delay = $urandom_range(3, 0);
        repeat (delay) begin
          @(negedge clock);
          check_value("bus_valid", bus_valid, 1'b1);
          check_value("bus_write", bus_write, w);
          check_value("bus_addr", bus_addr, a);
          check_value("bus_wdata", bus_wdata, wd);
          check_value("bus_size", bus_size, sz);
        end
        if (w) begin
          record_store(a, wd, sz);
        end else begin
          bus_rdata = read_bus_mem(a);
        end
        bus_ready = 1'b1;
      end
    end
  end

  initial begin : uart_monitor
    forever begin
      @(negedge clock);
      if (!reset && uart_valid) begin
        if (exp_uart.size() == 0) begin
          stop_with_failure("UART strobe seen after all model characters");
        end else begin
          check_value("uart_char", uart_char, exp_uart[0]);
          exp_uart.delete(0);
        end
      end
    end
  end

  initial begin : watchdog
    repeat (prog_len * 40) @(posedge clock);
    stop_with_failure("timeout, the program did not produce all expected events");
  end

  initial begin : main_flow
    void'($urandom(69726));
    reset = 1'b1;
    gen_program();
    run_model();
    for (int i = 0; i < prog_len; i++) begin
      for (int b = 0; b < 4; b++) begin
        bus_mem[word_t'(4 * i + b)] = p_word[i][8*b +: 8];
      end
    end
    repeat (4) begin
      @(negedge clock);
      check_value("bus_valid", bus_valid, 1'b0);
      check_value("uart_valid", uart_valid, 1'b0);
    end
    reset = 1'b0;
    while (exp_addr.size() != 0 || exp_uart.size() != 0) begin
      @(posedge clock);
    end
    // core spins on the final jump and must not write again
    repeat (20) @(posedge clock);
    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

/* riscv_core.sv */
// RV64 core top with a three-step in-order pipeline, a shared memory bus and a UART strobe
`default_nettype none

module riscv_core #(
  parameter core_pkg::word_t reset_pc  = '0,
  parameter core_pkg::word_t uart_addr = 64'h0000_0000_1000_0000
) (
  input  logic                clock,
  input  logic                reset,
  output logic                bus_valid,
  input  logic                bus_ready,
  output logic                bus_write,
  output core_pkg::word_t     bus_addr,
  output core_pkg::word_t     bus_wdata,
  output pipe_pkg::bus_size_e bus_size,
  input  core_pkg::word_t     bus_rdata,
  output logic                uart_valid,
  output logic [7:0]          uart_char
);
  import core_pkg::*;
  import pipe_pkg::*;

  logic       fetch_valid, fetch_allowin;
  fetch_pkt_t fetch_pkt;
  logic       ex_in_valid, ex_in_allowin;
  fetch_pkt_t ex_in_pkt;
  logic       ex_out_valid, ex_out_allowin;
  mem_pkt_t   ex_out_pkt;
  logic       mem_in_valid, mem_in_allowin;
  mem_pkt_t   mem_in_pkt;
  logic       redirect;
  word_t      redirect_pc;
  reg_idx_t   rs1_addr, rs2_addr;
  word_t      rs1_data, rs2_data;
  logic       wr_en;
  reg_idx_t   wr_addr;
  word_t      wr_data;
  logic       pend_valid;

  mem_bus_if fetch_bus ();
  mem_bus_if mem_bus ();

  // destination still to be written by the instruction in the memory slot
  assign pend_valid = mem_in_valid && mem_in_pkt.wr_rd;

  fetch_stage #(.reset_pc(reset_pc)) u_fetch (
    .clock(clock), .reset(reset), .bus(fetch_bus),
    .out_valid(fetch_valid), .out_pkt(fetch_pkt), .out_allowin(fetch_allowin),
    .redirect(redirect), .redirect_pc(redirect_pc)
  );

  stage_reg #(.payload_t(fetch_pkt_t)) u_fe_reg (
    .clock(clock), .reset(reset), .flush(redirect),
    .in_valid(fetch_valid), .in_data(fetch_pkt), .in_allowin(fetch_allowin),
    .out_valid(ex_in_valid), .out_data(ex_in_pkt), .out_allowin(ex_in_allowin)
  );

  execute_stage u_execute (
    .in_valid(ex_in_valid), .in_pkt(ex_in_pkt), .in_allowin(ex_in_allowin),
    .out_valid(ex_out_valid), .out_pkt(ex_out_pkt), .out_allowin(ex_out_allowin),
    .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .rs1_data(rs1_data), .rs2_data(rs2_data),
    .pend_valid(pend_valid), .pend_rd(mem_in_pkt.rd),
    .redirect(redirect), .redirect_pc(redirect_pc)
  );

  reg_file u_regs (
    .clock(clock), .reset(reset),
    .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .rs1_data(rs1_data), .rs2_data(rs2_data),
    .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data)
  );

  stage_reg #(.payload_t(mem_pkt_t)) u_em_reg (
    .clock(clock), .reset(reset), .flush(1'b0),
    .in_valid(ex_out_valid), .in_data(ex_out_pkt), .in_allowin(ex_out_allowin),
    .out_valid(mem_in_valid), .out_data(mem_in_pkt), .out_allowin(mem_in_allowin)
  );

  mem_wb_stage #(.uart_addr(uart_addr)) u_mem_wb (
    .in_valid(mem_in_valid), .in_pkt(mem_in_pkt), .in_allowin(mem_in_allowin),
    .bus(mem_bus), .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
    .uart_valid(uart_valid), .uart_char(uart_char)
  );

  bus_arbiter u_arbiter (
    .clock(clock), .reset(reset), .fetch_bus(fetch_bus), .mem_bus(mem_bus),
    .bus_valid(bus_valid), .bus_ready(bus_ready), .bus_write(bus_write),
    .bus_addr(bus_addr), .bus_wdata(bus_wdata), .bus_size(bus_size),
    .bus_rdata(bus_rdata)
  );

endmodule

`default_nettype wire

/* bus_arbiter.sv */
// bus arbiter that shares the external memory bus between the fetch and memory masters
`default_nettype none

module bus_arbiter (
  input  logic                  clock,
  input  logic                  reset,
  mem_bus_if.arbiter            fetch_bus,
  mem_bus_if.arbiter            mem_bus,
  output logic                  bus_valid,
  input  logic                  bus_ready,
  output logic                  bus_write,
  output core_pkg::word_t       bus_addr,
  output core_pkg::word_t       bus_wdata,
  output pipe_pkg::bus_size_e   bus_size,
  input  core_pkg::word_t       bus_rdata
);

  logic busy;
  logic owner_mem;
  logic grant_mem;

  // memory stage holds the older instruction, so it wins a tie
  assign grant_mem = busy ? owner_mem : mem_bus.valid;

  assign bus_valid = grant_mem ? mem_bus.valid : fetch_bus.valid;
  assign bus_write = grant_mem ? mem_bus.write : fetch_bus.write;
  assign bus_addr  = grant_mem ? mem_bus.addr  : fetch_bus.addr;
  assign bus_wdata = grant_mem ? mem_bus.wdata : fetch_bus.wdata;
  assign bus_size  = grant_mem ? mem_bus.size  : fetch_bus.size;

  assign mem_bus.ready   = grant_mem && bus_ready;
  assign mem_bus.rdata   = grant_mem ? bus_rdata : '0;
  assign fetch_bus.ready = !grant_mem && bus_ready;
  assign fetch_bus.rdata = grant_mem ? '0 : bus_rdata;

  // lock the owner of a started transfer until ready
  always_ff @(posedge clock) begin
    if (reset) begin
      busy      <= 1'b0;
      owner_mem <= 1'b0;
    end else if (bus_valid) begin
      busy      <= !bus_ready;
      owner_mem <= grant_mem;
    end
  end

endmodule

`default_nettype wire

/* mem_wb_stage.sv */
// memory/writeback stage with load/store bus access, UART byte strobe and register writeback
`default_nettype none

module mem_wb_stage #(
  parameter core_pkg::word_t uart_addr = 64'h0000_0000_1000_0000
) (
  input  logic               in_valid,
  input  pipe_pkg::mem_pkt_t in_pkt,
  output logic               in_allowin,
  mem_bus_if.master          bus,
  output logic               wr_en,
  output core_pkg::reg_idx_t wr_addr,
  output core_pkg::word_t    wr_data,
  output logic               uart_valid,
  output logic [7:0]         uart_char
);
  import pipe_pkg::*;

  logic is_uart;
  logic needs_bus;
  logic done;

  // SB to the UART address never reaches the bus
  assign is_uart = in_pkt.is_store && in_pkt.size == size_byte &&
                   in_pkt.result == uart_addr;

  assign needs_bus = (in_pkt.is_load || in_pkt.is_store) && !is_uart;

  assign bus.valid = in_valid && needs_bus;
  assign bus.write = in_pkt.is_store;
  assign bus.addr  = in_pkt.result;
  assign bus.wdata = in_pkt.store_data;
  assign bus.size  = in_pkt.size;

  // slot is held until the bus transfer completes
  assign in_allowin = !in_valid || !needs_bus || bus.ready;
  assign done       = in_valid && in_allowin;

  assign wr_en   = done && in_pkt.wr_rd;
  assign wr_addr = in_pkt.rd;
  assign wr_data = in_pkt.is_load ? bus.rdata : in_pkt.result;

  assign uart_valid = done && is_uart;
  assign uart_char  = in_pkt.store_data[7:0];

endmodule

`default_nettype wire

/* execute_stage.sv */
// execute stage with decode, operand read, hazard stall, ALU and branch resolution
`default_nettype none

module execute_stage (
  input  logic                 in_valid,
  input  pipe_pkg::fetch_pkt_t in_pkt,
  output logic                 in_allowin,
  output logic                 out_valid,
  output pipe_pkg::mem_pkt_t   out_pkt,
  input  logic                 out_allowin,
  output core_pkg::reg_idx_t   rs1_addr,
  output core_pkg::reg_idx_t   rs2_addr,
  input  core_pkg::word_t      rs1_data,
  input  core_pkg::word_t      rs2_data,
  input  logic                 pend_valid,
  input  core_pkg::reg_idx_t   pend_rd,
  output logic                 redirect,
  output core_pkg::word_t      redirect_pc
);
  import core_pkg::*;
  import pipe_pkg::*;

  inst_t      inst;
  logic [6:0] opcode;
  logic [2:0] funct3;
  reg_idx_t   rd;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;
  logic       use_rs1;
  logic       use_rs2;
  logic       writes_rd;
  logic       is_load;
  logic       is_store;
  logic       is_branch;
  logic       is_jal;
  alu_op_e    alu_op;
  word_t      alu_b;
  word_t      alu_result;
  word_t      link_pc;
  logic       hazard;
  logic       taken;
  logic       fire;

  function automatic alu_op_e alu_from_funct3(input logic [2:0] f3, input logic sub);
    case (f3)
      f3_and:  return alu_and;
      f3_or:   return alu_or;
      f3_xor:  return alu_xor;
      default: return sub ? alu_sub : alu_add;
    endcase
  endfunction

  assign inst     = in_pkt.inst;
  assign opcode   = inst[6:0];
  assign rd       = inst[11:7];
  assign funct3   = inst[14:12];
  assign rs1_addr = inst[19:15];
  assign rs2_addr = inst[24:20];

  assign imm_i = {{52{inst[31]}}, inst[31:20]};
  assign imm_s = {{52{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
  assign imm_j = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  // unknown opcodes fall to the defaults and behave as a no-op
  always_comb begin
    use_rs1   = 1'b0;
    use_rs2   = 1'b0;
    writes_rd = 1'b0;
    is_load   = 1'b0;
    is_store  = 1'b0;
    is_branch = 1'b0;
    is_jal    = 1'b0;
    alu_op    = alu_add;
    alu_b     = imm_i;
    case (opcode)
      opc_op_imm: begin
        use_rs1   = 1'b1;
        writes_rd = 1'b1;
        alu_op    = alu_from_funct3(funct3, 1'b0);
      end
      opc_op: begin
        use_rs1   = 1'b1;
        use_rs2   = 1'b1;
        writes_rd = 1'b1;
        alu_b     = rs2_data;
        alu_op    = alu_from_funct3(funct3, inst[30]);
      end
      opc_lui: begin
        writes_rd = 1'b1;
        alu_b     = imm_u;
        alu_op    = alu_pass_b;
      end
      opc_load: begin
        use_rs1   = 1'b1;
        writes_rd = 1'b1;
        is_load   = 1'b1;
      end
      opc_store: begin
        use_rs1  = 1'b1;
        use_rs2  = 1'b1;
        is_store = 1'b1;
        alu_b    = imm_s;
      end
      opc_branch: begin
        use_rs1   = 1'b1;
        use_rs2   = 1'b1;
        is_branch = 1'b1;
      end
      opc_jal: begin
        writes_rd = 1'b1;
        is_jal    = 1'b1;
      end
      default: ;
    endcase
  end

  always_comb begin
    case (alu_op)
      alu_sub:    alu_result = rs1_data - alu_b;
      alu_and:    alu_result = rs1_data & alu_b;
      alu_or:     alu_result = rs1_data | alu_b;
      alu_xor:    alu_result = rs1_data ^ alu_b;
      alu_pass_b: alu_result = alu_b;
      default:    alu_result = rs1_data + alu_b;
    endcase
  end

  // wait until the older instruction in the memory slot has written back
  assign hazard = pend_valid && (pend_rd != '0) &&
                  ((use_rs1 && pend_rd == rs1_addr) || (use_rs2 && pend_rd == rs2_addr));

  assign taken = is_jal ||
                 (is_branch && funct3 == f3_beq && rs1_data == rs2_data) ||
                 (is_branch && funct3 == f3_bne && rs1_data != rs2_data);

  assign fire       = in_valid && !hazard && out_allowin;
  assign in_allowin = out_allowin && !hazard;
  assign out_valid  = in_valid && !hazard;

  assign redirect    = fire && taken;
  assign redirect_pc = in_pkt.pc + (is_jal ? imm_j : imm_b);
  assign link_pc     = in_pkt.pc + xlen'(4);

  assign out_pkt.pc         = in_pkt.pc;
  assign out_pkt.rd         = rd;
  assign out_pkt.wr_rd      = writes_rd && (rd != '0);
  assign out_pkt.result     = is_jal ? link_pc : alu_result;
  assign out_pkt.is_load    = is_load;
  assign out_pkt.is_store   = is_store;
  assign out_pkt.size       = (funct3 == f3_byte) ? size_byte : size_dword;
  assign out_pkt.store_data = rs2_data;

endmodule

`default_nettype wire

/* fetch_stage.sv */
// fetch stage with the program counter, one outstanding fetch and discard of stale fetches
`default_nettype none

module fetch_stage #(
  parameter core_pkg::word_t reset_pc = '0
) (
  input  logic                 clock,
  input  logic                 reset,
  mem_bus_if.master            bus,
  output logic                 out_valid,
  output pipe_pkg::fetch_pkt_t out_pkt,
  input  logic                 out_allowin,
  input  logic                 redirect,
  input  core_pkg::word_t      redirect_pc
);
  import core_pkg::*;
  import pipe_pkg::*;

  word_t pc;
  word_t target_pc;
  logic  req_valid;
  logic  discard;
  logic  buf_valid;
  inst_t buf_inst;
  logic  accept;

  assign bus.valid = req_valid;
  assign bus.write = 1'b0;
  assign bus.addr  = pc;
  assign bus.wdata = '0;
  assign bus.size  = size_dword;

  assign accept    = buf_valid && out_allowin;
  assign out_valid = buf_valid;
  assign out_pkt   = '{pc: pc, inst: buf_inst};

  always_ff @(posedge clock) begin
    if (reset) begin
      pc        <= reset_pc;
      req_valid <= 1'b0;
      discard   <= 1'b0;
      buf_valid <= 1'b0;
    end else if (redirect) begin
      buf_valid <= 1'b0;
      if (req_valid && !bus.ready) begin
        // request must stay steady on the bus, so finish it and drop the data
        discard   <= 1'b1;
        target_pc <= redirect_pc;
      end else begin
        pc        <= redirect_pc;
        req_valid <= 1'b1;
        discard   <= 1'b0;
      end
    end else begin
      if (req_valid && bus.ready) begin
        if (discard) begin
          discard <= 1'b0;
          pc      <= target_pc;
        end else begin
          req_valid <= 1'b0;
          buf_valid <= 1'b1;
          buf_inst  <= bus.rdata[31:0];
        end
      end else if (!req_valid && !buf_valid) begin
        req_valid <= 1'b1;
      end
      // next fetch starts as soon as the held instruction leaves
      if (accept) begin
        buf_valid <= 1'b0;
        pc        <= pc + xlen'(4);
        req_valid <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* stage_reg.sv */
// pipeline register slot with valid/allowin handshake and flush for any payload type
`default_nettype none

module stage_reg #(
  parameter type payload_t = logic
) (
  input  logic     clock,
  input  logic     reset,
  input  logic     flush,
  input  logic     in_valid,
  input  payload_t in_data,
  output logic     in_allowin,
  output logic     out_valid,
  output payload_t out_data,
  input  logic     out_allowin
);

  logic valid_q;

  // take new data when empty or when the held entry leaves this cycle
  assign in_allowin = !valid_q || out_allowin;
  assign out_valid  = valid_q;

  always_ff @(posedge clock) begin
    if (reset || flush) begin
      valid_q <= 1'b0;
    end else if (in_allowin) begin
      valid_q <= in_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (in_allowin && in_valid) begin
      out_data <= in_data;
    end
  end

endmodule

`default_nettype wire

/* reg_file.sv */
// 32 x 64-bit register file with two read ports, one write port and x0 reading zero
`default_nettype none

module reg_file (
  input  logic               clock,
  input  logic               reset,
  input  core_pkg::reg_idx_t rs1_addr,
  input  core_pkg::reg_idx_t rs2_addr,
  output core_pkg::word_t    rs1_data,
  output core_pkg::word_t    rs2_data,
  input  logic               wr_en,
  input  core_pkg::reg_idx_t wr_addr,
  input  core_pkg::word_t    wr_data
);
  import core_pkg::*;

  word_t regs [32];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && wr_addr != '0) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // execute stalls on a pending write instead of using a bypass
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

/* mem_bus_if.sv */
// memory bus interface for one master with a valid/ready handshake and read data
`default_nettype none

interface mem_bus_if;
  import core_pkg::*;
  import pipe_pkg::*;

  logic      valid;
  logic      ready;
  logic      write;
  word_t     addr;
  word_t     wdata;
  bus_size_e size;
  word_t     rdata;

  modport master (output valid, write, addr, wdata, size, input ready, rdata);

  modport arbiter (input valid, write, addr, wdata, size, output ready, rdata);

endinterface

`default_nettype wire

/* pipe_pkg.sv */
// pipeline package with the bus access size and the payloads passed between core stages
`default_nettype none

package pipe_pkg;

  // one bit is enough for the two widths the core uses
  typedef enum logic {
    size_byte  = 1'b0,
    size_dword = 1'b1
  } bus_size_e;

  // fetch to execute
  typedef struct packed {
    core_pkg::word_t pc;
    core_pkg::inst_t inst;
  } fetch_pkt_t;

  // execute to memory/writeback
  typedef struct packed {
    core_pkg::word_t    pc;
    core_pkg::reg_idx_t rd;
    logic               wr_rd;
    // alu result, link value, or effective address for loads and stores
    core_pkg::word_t    result;
    logic               is_load;
    logic               is_store;
    bus_size_e          size;
    core_pkg::word_t    store_data;
  } mem_pkt_t;

  // data on the bus is right-justified to addr
  // a byte write uses wdata[7:0] and a read returns the bytes starting at addr

endpackage

`default_nettype wire

/* core_pkg.sv */
// core ISA package with data widths, opcodes, funct3 codes and ALU operations of the RV64 subset
`default_nettype none

package core_pkg;

  localparam int unsigned xlen = 64;

  typedef logic [xlen-1:0] word_t;
  typedef logic [31:0] inst_t;
  typedef logic [4:0] reg_idx_t;

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    opc_op_imm = 7'b0010011,
    opc_op     = 7'b0110011,
    opc_lui    = 7'b0110111,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_branch = 7'b1100011,
    opc_jal    = 7'b1101111
  } opcode_e;

  // alu funct3
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_and     = 3'b111;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_xor     = 3'b100;

  // branch funct3
  localparam logic [2:0] f3_beq = 3'b000;
  localparam logic [2:0] f3_bne = 3'b001;

  // load/store width funct3
  localparam logic [2:0] f3_byte  = 3'b000;
  localparam logic [2:0] f3_dword = 3'b011;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_pass_b
  } alu_op_e;

endpackage

`default_nettype wire
